// ==== build.f ====
logic/cpu_pkg.sv
logic/cpu_alu.sv
logic/cpu_regfile.sv
logic/cpu_sequencer.sv
logic/cpu_top.sv
verification/tb_cpu_memory.sv
verification/cpu_top_assert.sv
verification/tb_cpu_top.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_cpu_top -Mdir obj_dir -o sim_cpu
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_cpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides pass or fail
if grep -q -F "*** TEST PASSED ***" sim.log; then
    exit 0
else
    echo "pass message not found in sim.log"
    exit 1
fi

// ==== verification/tb_cpu_top.sv ====
module tb_cpu_top import cpu_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam addr_t boot_addr   = 32'hffc0_0000;
    localparam int    mem_wait    = 3;
    localparam addr_t data_base   = boot_addr + 32'h1000;
    localparam int    run_budget  = 300; // cycles per program run including reset
    localparam int    num_runs    = 8 + 8 + 1 + 6 + 32 + 1 + 1;
    localparam int    watchdog_ns = 2 * num_runs * run_budget * 10;
    localparam word_t mark_fall   = 32'h0f0f_1111;
    localparam word_t mark_taken  = 32'h7a7a_2222;

    logic   clk;
    logic   rst_n;
    half_t  data_in;
    addr_t  addrbus;
    half_t  data_out;
    logic   write_out;
    flags_t ccr;
    int     prog_ptr; // byte offset of the next program word

    cpu_top #(
        .boot_addr (boot_addr),
        .mem_wait  (mem_wait)
    ) u_cpu_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .data_in   (data_in),
        .addrbus   (addrbus),
        .data_out  (data_out),
        .write_out (write_out),
        .ccr       (ccr)
    );

    tb_cpu_memory u_mem (
        .clk   (clk),
        .addr  (addrbus),
        .wdata (data_out),
        .we    (write_out),
        .rdata (data_in)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        $display("Error: watchdog expired before the tests finished");
        $display("*** TEST FAILED ***");
        $fatal(1);
    end

    task automatic stop_run();
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic fail_plain(string what);
        $display("Error at %0t: %s", $time, what);
        stop_run();
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flags(string name, flags_t got, flags_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_addr(string name, addr_t got, addr_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    function automatic word_t alu_model(alu_func_t f, word_t a, word_t b);
        case (f)
            alu_and: return a & b;
            alu_or:  return a | b;
            alu_add: return a + b;
            alu_sub: return a - b;
            alu_xor: return a ^ b;
            alu_shl: return a << 1;
            alu_shr: return a >> 1;
            default: return b;
        endcase
    endfunction

    function automatic flags_t cmp_model(word_t a, word_t b);
        flags_t f;
        word_t  d;
        longint exact;
        d          = a - b;
        exact      = longint'($signed(a)) - longint'($signed(b));
        f.carry    = a < b; // borrow
        f.negative = d[31];
        f.overflow = exact != longint'($signed(d)); // true difference does not fit
        f.zero     = d == 32'd0;
        return f;
    endfunction

    function automatic logic branch_model(opcode_t op, word_t a, word_t b);
        case (op)
            op_bra:  return 1'b1;
            op_beq:  return a == b;
            op_bne:  return a != b;
            op_bgt:  return $signed(a) > $signed(b);
            op_bge:  return $signed(a) >= $signed(b);
            op_ble:  return $signed(a) <= $signed(b);
            op_blt:  return $signed(a) < $signed(b);
            default: return 1'b0;
        endcase
    endfunction

    function automatic half_t instr(addr_mode_t mode, opcode_t op, reg_idx_t ra);
        instr_t w;
        w = '{mode: mode, op: op, ra: ra};
        return half_t'(w);
    endfunction

    function automatic half_t reg_pair(reg_idx_t rb, reg_idx_t rc);
        return {3'b000, rb, 3'b000, rc};
    endfunction

    // big-endian so the high half comes first
    function automatic word_t read_word(addr_t a);
        return {u_mem.peek(a), u_mem.peek(a + 32'd2)};
    endfunction

    task automatic emit(half_t w);
        u_mem.poke(boot_addr + addr_t'(prog_ptr), w);
        prog_ptr += 2;
    endtask

    task automatic emit_pair(addr_mode_t mode, opcode_t op, reg_idx_t ra, half_t w2);
        emit(instr(mode, op, ra));
        emit(w2);
    endtask

    task automatic emit_long(addr_mode_t mode, opcode_t op, reg_idx_t ra, word_t v);
        emit(instr(mode, op, ra));
        emit(v[31:16]);
        emit(v[15:0]);
    endtask

    task automatic emit_halt();
        addr_t here;
        here = boot_addr + addr_t'(prog_ptr);
        emit_long(am_dir, op_jmp, 5'd0, here);
    endtask

    task automatic begin_program();
        rst_n    = 1'b0;
        prog_ptr = 0;
    endtask

    task automatic release_reset();
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_addr("addrbus in reset", addrbus, boot_addr);
        check_flags("ccr in reset", ccr, flags_t'(4'b0000));
        check_bit("write_out in reset", write_out, 1'b0);
        @(posedge clk);
        #1 rst_n = 1'b1;
    endtask

    task automatic wait_write(addr_t a);
        int   n;
        logic seen;
        seen = 1'b0;
        for (n = 0; n < run_budget && !seen; n++) begin
            @(negedge clk);
            seen = write_out && (addrbus == a);
        end
        if (!seen) begin
            fail_plain($sformatf("no write to %h within %0d cycles", a, run_budget));
        end else begin
            @(posedge clk); // memory takes the write here
            #1;
        end
    endtask

    task automatic test_alu_rr();
        word_t a;
        word_t b;
        for (int f = 0; f < 8; f++) begin
            a = $urandom();
            b = $urandom();
            begin_program();
            emit_long(am_imm, op_ldi, 5'd1, a);
            emit_long(am_imm, op_ldi, 5'd2, b);
            emit_pair(am_reg, op_alu_rr | opcode_t'(f), 5'd3, reg_pair(5'd1, 5'd2));
            emit_long(am_dir, op_st_l, 5'd3, data_base);
            emit_halt();
            release_reset();
            wait_write(data_base + 32'd2);
            check_word($sformatf("rr result func %0d", f), read_word(data_base),
                       alu_model(alu_func_t'(f), a, b));
        end
    endtask

    task automatic test_alu_imm();
        word_t a;
        half_t imm;
        for (int f = 0; f < 8; f++) begin
            a   = $urandom();
            imm = half_t'($urandom());
            begin_program();
            emit_long(am_imm, op_ldi, 5'd4, a);
            emit_pair(am_imm, op_alu_imm | opcode_t'(f), 5'd4, imm);
            emit_long(am_dir, op_st_l, 5'd4, data_base);
            emit_halt();
            release_reset();
            wait_write(data_base + 32'd2);
            check_word($sformatf("imm result func %0d", f), read_word(data_base),
                       alu_model(alu_func_t'(f), a, {{16{imm[15]}}, imm}));
        end
    endtask

    task automatic test_inc_dec_mov();
        word_t a;
        a = $urandom();
        begin_program();
        emit_long(am_imm, op_ldi, 5'd5, a);
        emit(instr(am_reg, op_inc, 5'd5));
        emit_long(am_dir, op_st_l, 5'd5, data_base);
        emit(instr(am_reg, op_dec, 5'd5));
        emit(instr(am_reg, op_dec, 5'd5));
        emit_pair(am_reg, op_mov, 5'd7, reg_pair(5'd5, 5'd0));
        emit_long(am_dir, op_st_l, 5'd7, data_base + 32'd4);
        emit_halt();
        release_reset();
        wait_write(data_base + 32'd6);
        check_word("inc result", read_word(data_base), a + 32'd1);
        check_word("dec and mov result", read_word(data_base + 32'd4), a - 32'd1);
    endtask

    task automatic test_cmp();
        word_t pa [6];
        word_t pb [6];
        pa = '{$urandom(), $urandom(), $urandom(), 32'h7fff_ffff, 32'h8000_0000, 32'd1};
        pb = '{$urandom(), $urandom(), 32'd0, 32'h8000_0000, 32'd1, 32'hffff_ffff};
        pb[2] = pa[2]; // equal pair
        for (int p = 0; p < 6; p++) begin
            begin_program();
            emit_long(am_imm, op_ldi, 5'd1, pa[p]);
            emit_long(am_imm, op_ldi, 5'd2, pb[p]);
            emit_pair(am_reg, op_cmp, 5'd1, reg_pair(5'd2, 5'd0));
            emit_long(am_dir, op_st_l, 5'd1, data_base);
            emit_halt();
            release_reset();
            wait_write(data_base + 32'd2);
            check_flags($sformatf("ccr after cmp %h %h", pa[p], pb[p]), ccr,
                        cmp_model(pa[p], pb[p]));
        end
    endtask

    task automatic test_branches();
        opcode_t ops [8];
        word_t   pa [4];
        word_t   pb [4];
        logic    taken;
        ops = '{op_bra, op_beq, op_bne, op_bgt, op_bge, op_ble, op_blt, op_brn};
        pa  = '{32'd5, 32'hffff_fffd, 32'd7, 32'h8000_0000};
        pb  = '{32'd5, 32'd7, 32'hffff_fffd, 32'd1};
        for (int i = 0; i < 8; i++) begin
            for (int p = 0; p < 4; p++) begin
                begin_program();
                emit_long(am_imm, op_ldi, 5'd3, mark_fall);
                emit_long(am_imm, op_ldi, 5'd4, mark_taken);
                emit_long(am_imm, op_ldi, 5'd1, pa[p]);
                emit_long(am_imm, op_ldi, 5'd2, pb[p]);
                emit_pair(am_reg, op_cmp, 5'd1, reg_pair(5'd2, 5'd0));
                emit_pair(am_pcind, ops[i], 5'd0, 16'd12); // skips store and jmp
                emit_long(am_dir, op_st_l, 5'd3, data_base);
                emit_long(am_dir, op_jmp, 5'd0, boot_addr + addr_t'(prog_ptr + 12));
                emit_long(am_dir, op_st_l, 5'd4, data_base);
                emit_halt();
                release_reset();
                wait_write(data_base + 32'd2);
                taken = branch_model(ops[i], pa[p], pb[p]);
                check_word($sformatf("marker op %h pair %0d", ops[i], p),
                           read_word(data_base), taken ? mark_taken : mark_fall);
            end
        end
    endtask

    task automatic test_copy();
        word_t val;
        val = $urandom();
        begin_program();
        u_mem.poke(data_base + 32'h20, val[31:16]);
        u_mem.poke(data_base + 32'h22, val[15:0]);
        emit_long(am_dir, op_jmp, 5'd0, boot_addr + 32'h100);
        prog_ptr = 32'h100;
        emit_long(am_dir, op_ld_l, 5'd9, data_base + 32'h20);
        emit_long(am_dir, op_st_l, 5'd9, data_base + 32'h40);
        emit_halt();
        release_reset();
        wait_write(data_base + 32'h42);
        check_word("copied word", read_word(data_base + 32'h40), val);
    endtask

    task automatic test_fault();
        addr_t frozen;
        begin_program();
        emit_long(am_imm, op_ldi, 5'd1, 32'h0bad_c0de);
        emit_long(am_dir, op_st_l, 5'd1, data_base);
        emit(instr(am_inh, 8'hff, 5'd0)); // undefined operation
        frozen = boot_addr + addr_t'(prog_ptr); // pc already past the bad word
        release_reset();
        wait_write(data_base + 32'd2);
        repeat (8) @(posedge clk); // one fetch and eval before fault
        for (int n = 0; n < 50; n++) begin
            @(negedge clk);
            check_bit("write_out in fault", write_out, 1'b0);
            check_addr("addrbus in fault", addrbus, frozen);
        end
    endtask

    initial begin
        rst_n    = 1'b0;
        prog_ptr = 0;
        void'($urandom(43528));
        repeat (2) @(posedge clk); // memory fill settles first
        #1;
        test_alu_rr();
        test_alu_imm();
        test_inc_dec_mov();
        test_cmp();
        test_branches();
        test_copy();
        test_fault();
        if (u_cpu_top.u_cpu_top_assert.fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("Error: %0d bus assertion failures",
                     u_cpu_top.u_cpu_top_assert.fail_count);
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== verification/cpu_top_assert.sv ====
module cpu_top_assert import cpu_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    input addr_t addrbus,
    input logic  write_out
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    write_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        write_out |-> !addrbus[0])
        else begin
            fail_count++;
            $error("write_out high on odd address %h", addrbus);
        end

    // each halfword write is a single pulse
    write_single: assert property (@(posedge clk) disable iff (!rst_n)
        write_out |=> !write_out)
        else begin
            fail_count++;
            $error("write_out high in two consecutive cycles");
        end

    addr_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(addrbus))
        else begin
            fail_count++;
            $error("addrbus has unknown bits");
        end

endmodule

bind cpu_top cpu_top_assert u_cpu_top_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .addrbus   (addrbus),
    .write_out (write_out)
);

// ==== verification/tb_cpu_memory.sv ====
module tb_cpu_memory import cpu_pkg::*; (
    input  logic  clk,
    input  addr_t addr,
    input  half_t wdata,
    input  logic  we,
    output half_t rdata
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int depth = 2 ** 15; // halfword entries over the low 16 address bits

    half_t mem [depth];

    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = half_t'(i << 1) ^ 16'h5ac3; // every address bit shows
        end
    end

    assign rdata = mem[addr[15:1]];

    always @(posedge clk) begin
        if (we) begin
            mem[addr[15:1]] <= wdata;
        end
    end

    // backdoor access for program loading and result checks
    task automatic poke(addr_t a, half_t v);
        mem[a[15:1]] <= v;
    endtask

    function automatic half_t peek(addr_t a);
        return mem[a[15:1]];
    endfunction

endmodule

// ==== logic/cpu_top.sv ====
module cpu_top import cpu_pkg::*; #(
    parameter addr_t boot_addr = 32'hffc0_0000,
    parameter int    mem_wait  = 3
) (
    input  logic   clk,
    input  logic   rst_n,
    input  half_t  data_in,
    output addr_t  addrbus,
    output half_t  data_out,
    output logic   write_out,
    output flags_t ccr
);

    alu_req_t alu_req;
    alu_rsp_t alu_rsp;
    reg_idx_t rd_idx_a;
    reg_idx_t rd_idx_b;
    word_t    rd_data_a;
    word_t    rd_data_b;
    reg_wr_t  reg_wr;

    cpu_sequencer #(
        .boot_addr (boot_addr),
        .mem_wait  (mem_wait)
    ) u_sequencer (
        .clk       (clk),
        .rst_n     (rst_n),
        .data_in   (data_in),
        .addrbus   (addrbus),
        .data_out  (data_out),
        .write_out (write_out),
        .ccr       (ccr),
        .alu_req   (alu_req),
        .alu_rsp   (alu_rsp),
        .rd_idx_a  (rd_idx_a),
        .rd_idx_b  (rd_idx_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .reg_wr    (reg_wr)
    );

    cpu_alu u_alu (
        .req (alu_req),
        .rsp (alu_rsp)
    );

    cpu_regfile u_regfile (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_idx_a  (rd_idx_a),
        .rd_idx_b  (rd_idx_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wr        (reg_wr)
    );

endmodule

// ==== logic/cpu_sequencer.sv ====
module cpu_sequencer import cpu_pkg::*; #(
    parameter addr_t boot_addr = 32'hffc0_0000,
    parameter int    mem_wait  = 3
) (
    input  logic     clk,
    input  logic     rst_n,
    input  half_t    data_in,
    output addr_t    addrbus,
    output half_t    data_out,
    output logic     write_out,
    output flags_t   ccr,
    output alu_req_t alu_req,
    input  alu_rsp_t alu_rsp,
    output reg_idx_t rd_idx_a,
    output reg_idx_t rd_idx_b,
    input  word_t    rd_data_a,
    input  word_t    rd_data_b,
    output reg_wr_t  reg_wr
);

    localparam int   cnt_w     = $clog2(mem_wait + 1);
    localparam logic addr_pc   = 1'b0;
    localparam logic addr_mar  = 1'b1;
    localparam logic half_high = 1'b0;
    localparam logic half_low  = 1'b1;

    seq_state_t       state, state_next;
    addr_t            pc, pc_next;
    addr_t            mar, mar_next;
    word_t            mdr, mdr_next;
    instr_t           ir, ir_next;
    logic [cnt_w-1:0] wait_cnt, wait_cnt_next;
    logic             addr_sel, addr_sel_next;
    logic             half_sel, half_sel_next;
    flags_t           ccr_next;
    logic             write_next;
    logic             take_branch;
    word_t            imm_sext;

    assign addrbus  = (addr_sel == addr_mar) ? mar : pc;
    assign data_out = (half_sel == half_low) ? mdr[15:0] : mdr[31:16];
    assign imm_sext = {{16{data_in[15]}}, data_in};

    // signed compares use n xor v
    always_comb begin
        case (ir.op)
            op_bra:  take_branch = 1'b1;
            op_beq:  take_branch = ccr.zero;
            op_bne:  take_branch = !ccr.zero;
            op_bgt:  take_branch = !(ccr.zero | (ccr.negative ^ ccr.overflow));
            op_bge:  take_branch = !(ccr.negative ^ ccr.overflow);
            op_ble:  take_branch = ccr.zero | (ccr.negative ^ ccr.overflow);
            op_blt:  take_branch = ccr.negative ^ ccr.overflow;
            default: take_branch = 1'b0; // brn
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= fetch1;
            pc        <= boot_addr;
            wait_cnt  <= '0;
            addr_sel  <= addr_pc;
            half_sel  <= half_low;
            ccr       <= '0;
            write_out <= 1'b0;
        end else begin
            state     <= state_next;
            pc        <= pc_next;
            wait_cnt  <= wait_cnt_next;
            addr_sel  <= addr_sel_next;
            half_sel  <= half_sel_next;
            ccr       <= ccr_next;
            write_out <= write_next;
        end
    end

    always_ff @(posedge clk) begin
        ir  <= ir_next;
        mar <= mar_next;
        mdr <= mdr_next;
    end

    always_comb begin
        state_next    = state;
        pc_next       = pc;
        mar_next      = mar;
        mdr_next      = mdr;
        ir_next       = ir;
        wait_cnt_next = wait_cnt;
        addr_sel_next = addr_sel;
        half_sel_next = half_sel;
        ccr_next      = ccr;
        write_next    = 1'b0;
        rd_idx_a      = ir.ra;
        rd_idx_b      = ir.ra;
        alu_req       = '{func: alu_add, a: '0, b: '0};
        reg_wr        = '{idx: ir.ra, data: alu_rsp.result, lanes: lanes_none};

        case (state)
            fetch1, fetch2, fetch3: begin
                if (wait_cnt == '0) begin
                    addr_sel_next = addr_pc;
                    wait_cnt_next = cnt_w'(mem_wait);
                end else begin
                    wait_cnt_next = wait_cnt - 1'b1;
                    if (wait_cnt == cnt_w'(1)) begin // data_in valid now
                        pc_next = pc + 32'd2;
                        case (state)
                            fetch1: begin
                                ir_next    = instr_t'(data_in);
                                state_next = eval1;
                            end
                            fetch2: begin
                                state_next = eval2;
                                case (ir.mode)
                                    am_pcind: mar_next        = imm_sext;
                                    am_imm:   mdr_next        = imm_sext;
                                    am_dir:   mar_next[31:16] = data_in;
                                    default:  mdr_next        = {16'h0000, data_in};
                                endcase
                            end
                            default: begin
                                state_next = eval3;
                                if (ir.mode == am_dir) begin
                                    mar_next[15:0] = data_in;
                                end else begin
                                    mdr_next = {mdr[15:0], data_in};
                                end
                            end
                        endcase
                    end
                end
            end
            eval1: begin
                casez ({ir.mode, ir.op})
                    {am_inh, op_nop}: state_next = fetch1;
                    {am_reg, op_inc}, {am_reg, op_dec}: begin
                        alu_req.func = (ir.op == op_inc) ? alu_add : alu_sub;
                        alu_req.a    = rd_data_a;
                        alu_req.b    = 32'd1;
                        reg_wr.lanes = lanes_all;
                        state_next   = fetch1;
                    end
                    {am_reg, op_alu_rr[7:3], 3'b???},
                    {am_imm, op_alu_imm[7:3], 3'b???},
                    {am_reg, op_mov}, {am_reg, op_cmp}, {am_imm, op_ldi},
                    {am_pcind, op_bra}, {am_pcind, op_beq}, {am_pcind, op_bne},
                    {am_pcind, op_bgt}, {am_pcind, op_bge}, {am_pcind, op_ble},
                    {am_pcind, op_blt}, {am_pcind, op_brn},
                    {am_dir, op_st_l}, {am_dir, op_ld_l}, {am_dir, op_jmp}:
                        state_next = fetch2;
                    default: state_next = fault;
                endcase
            end
            eval2: begin
                casez ({ir.mode, ir.op})
                    {am_reg, op_alu_rr[7:3], 3'b???}: begin
                        rd_idx_a     = mdr[12:8]; // rB
                        rd_idx_b     = mdr[4:0];  // rC
                        alu_req      = '{func: alu_func_t'(ir.op[2:0]), a: rd_data_a,
                                         b: rd_data_b};
                        reg_wr.lanes = lanes_all;
                        state_next   = fetch1;
                    end
                    {am_imm, op_alu_imm[7:3], 3'b???}: begin
                        alu_req      = '{func: alu_func_t'(ir.op[2:0]), a: rd_data_a, b: mdr};
                        reg_wr.lanes = lanes_all;
                        state_next   = fetch1;
                    end
                    {am_reg, op_mov}: begin
                        rd_idx_a     = mdr[12:8];
                        reg_wr.data  = rd_data_a;
                        reg_wr.lanes = lanes_all;
                        state_next   = fetch1;
                    end
                    {am_reg, op_cmp}: begin
                        rd_idx_b   = mdr[12:8];
                        alu_req    = '{func: alu_sub, a: rd_data_a, b: rd_data_b};
                        ccr_next   = alu_rsp.flags;
                        state_next = fetch1;
                    end
                    {am_pcind, op_bra}, {am_pcind, op_beq}, {am_pcind, op_bne},
                    {am_pcind, op_bgt}, {am_pcind, op_bge}, {am_pcind, op_ble},
                    {am_pcind, op_blt}, {am_pcind, op_brn}: begin
                        if (take_branch) begin
                            pc_next = pc + mar; // offset from the next instruction
                        end
                        state_next = pc_wait;
                    end
                    {am_imm, op_ldi}, {am_dir, op_st_l}, {am_dir, op_ld_l}, {am_dir, op_jmp}:
                        state_next = fetch3;
                    default: state_next = fault;
                endcase
            end
            eval3: begin
                case ({ir.mode, ir.op})
                    {am_imm, op_ldi}: begin
                        reg_wr.data  = mdr;
                        reg_wr.lanes = lanes_all;
                        state_next   = fetch1;
                    end
                    {am_dir, op_st_l}: begin
                        mdr_next      = rd_data_a;
                        half_sel_next = half_high; // high half goes first
                        addr_sel_next = addr_mar;
                        write_next    = 1'b1;
                        state_next    = store1;
                    end
                    {am_dir, op_ld_l}: begin
                        addr_sel_next = addr_mar;
                        state_next    = load1;
                    end
                    {am_dir, op_jmp}: begin
                        pc_next    = mar;
                        state_next = fetch1;
                    end
                    default: state_next = fault;
                endcase
            end
            store1: state_next = store2;
            store2: begin
                half_sel_next = half_low;
                mar_next      = mar + 32'd2;
                write_next    = 1'b1;
                state_next    = store3;
            end
            store3: begin
                addr_sel_next = addr_pc;
                state_next    = fetch1;
            end
            load1: state_next = load2;
            load2: begin
                reg_wr.data  = {data_in, 16'h0000};
                reg_wr.lanes = lanes_high;
                mar_next     = mar + 32'd2;
                state_next   = load3;
            end
            load3: state_next = load4;
            load4: begin
                reg_wr.data   = {16'h0000, data_in};
                reg_wr.lanes  = lanes_low;
                addr_sel_next = addr_pc;
                state_next    = fetch1;
            end
            pc_wait: state_next = fetch1;
            default: state_next = fault; // stuck until reset
        endcase
    end

endmodule

// ==== logic/cpu_regfile.sv ====
module cpu_regfile import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rd_idx_a,
    input  reg_idx_t rd_idx_b,
    output word_t    rd_data_a,
    output word_t    rd_data_b,
    input  reg_wr_t  wr
);

    localparam int num_regs = 2 ** $bits(reg_idx_t);

    word_t regs [num_regs];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // only the enabled byte lanes change
            for (int lane = 0; lane < $bits(reg_lanes_t); lane++) begin
                if (wr.lanes[lane]) begin
                    regs[wr.idx][lane*8 +: 8] <= wr.data[lane*8 +: 8];
                end
            end
        end
    end

    assign rd_data_a = regs[rd_idx_a];
    assign rd_data_b = regs[rd_idx_b];

endmodule

// ==== logic/cpu_alu.sv ====
module cpu_alu import cpu_pkg::*; (
    input  alu_req_t req,
    output alu_rsp_t rsp
);

    logic [32:0] sum;
    word_t       result;
    logic        carry;
    logic        overflow;

    always_comb begin
        sum      = '0;
        carry    = 1'b0;
        overflow = 1'b0;
        case (req.func)
            alu_and: result = req.a & req.b;
            alu_or:  result = req.a | req.b;
            alu_add: begin
                sum      = {1'b0, req.a} + {1'b0, req.b};
                result   = sum[31:0];
                carry    = sum[32];
                overflow = (req.a[31] == req.b[31]) && (result[31] != req.a[31]);
            end
            alu_sub: begin
                sum      = {1'b0, req.a} - {1'b0, req.b};
                result   = sum[31:0];
                carry    = sum[32]; // borrow, a below b unsigned
                overflow = (req.a[31] != req.b[31]) && (result[31] != req.a[31]);
            end
            alu_xor: result = req.a ^ req.b;
            alu_shl: result = {req.a[30:0], 1'b0};
            alu_shr: result = {1'b0, req.a[31:1]};
            default: result = req.b; // pass
        endcase
    end

    assign rsp.result         = result;
    assign rsp.flags.carry    = carry;
    assign rsp.flags.negative = result[31];
    assign rsp.flags.overflow = overflow;
    assign rsp.flags.zero     = (result == '0);

endmodule

// ==== logic/cpu_pkg.sv ====
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [15:0] half_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [7:0]  opcode_t;
    typedef logic [3:0]  reg_lanes_t;

    typedef enum logic [2:0] {
        am_inh   = 3'd0,
        am_imm   = 3'd1,
        am_reg   = 3'd3,
        am_dir   = 3'd4,
        am_pcind = 3'd5
    } addr_mode_t;

    typedef enum logic [2:0] {
        alu_and  = 3'd0,
        alu_or   = 3'd1,
        alu_add  = 3'd2,
        alu_sub  = 3'd3,
        alu_xor  = 3'd4,
        alu_shl  = 3'd5,
        alu_shr  = 3'd6,
        alu_pass = 3'd7
    } alu_func_t;

    typedef enum logic [3:0] {
        fetch1, eval1,
        fetch2, eval2,
        fetch3, eval3,
        store1, store2, store3,
        load1, load2, load3, load4,
        pc_wait,
        fault
    } seq_state_t;

    // first instruction word, mode in the top bits
    typedef struct packed {
        addr_mode_t mode;
        opcode_t    op;
        reg_idx_t   ra;
    } instr_t;

    typedef struct packed {
        logic carry;
        logic negative;
        logic overflow;
        logic zero;
    } flags_t;

    typedef struct packed {
        alu_func_t func;
        word_t     a;
        word_t     b;
    } alu_req_t;

    typedef struct packed {
        word_t  result;
        flags_t flags;
    } alu_rsp_t;

    typedef struct packed {
        reg_idx_t   idx;
        word_t      data;
        reg_lanes_t lanes;
    } reg_wr_t;

    localparam reg_lanes_t lanes_none = 4'b0000;
    localparam reg_lanes_t lanes_low  = 4'b0011;
    localparam reg_lanes_t lanes_high = 4'b1100;
    localparam reg_lanes_t lanes_all  = 4'b1111;

    localparam opcode_t op_nop     = 8'h00; // inh
    localparam opcode_t op_alu_rr  = 8'h00; // reg, low 3 bits select the alu function
    localparam opcode_t op_alu_imm = 8'h10; // imm, low 3 bits select the alu function
    localparam opcode_t op_mov     = 8'h10; // reg
    localparam opcode_t op_cmp     = 8'h11; // reg
    localparam opcode_t op_inc     = 8'h13; // reg
    localparam opcode_t op_dec     = 8'h14; // reg
    localparam opcode_t op_ldi     = 8'h20; // imm
    localparam opcode_t op_bra     = 8'h20; // pcind
    localparam opcode_t op_beq     = 8'h21;
    localparam opcode_t op_bne     = 8'h22;
    localparam opcode_t op_bgt     = 8'h24;
    localparam opcode_t op_bge     = 8'h25;
    localparam opcode_t op_ble     = 8'h26;
    localparam opcode_t op_blt     = 8'h27;
    localparam opcode_t op_brn     = 8'h2c;
    localparam opcode_t op_st_l    = 8'h20; // dir
    localparam opcode_t op_ld_l    = 8'h21; // dir
    localparam opcode_t op_jmp     = 8'h50; // dir

endpackage
